/* files.f */
wave_pkg.sv
wave_regs.sv
wave_channel.sv
vector_wave_gen.sv
tb_vector_wave_gen.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the vector waveform generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_vector_wave_gen -f files.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
exit 0

/* tb_vector_wave_gen.sv */
// Vector waveform generator testbench
`default_nettype none

module tb_vector_wave_gen
    import wave_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period = 4;

    logic                      clk;
    logic                      reset;
    logic [apb_addr_width-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [apb_data_width-1:0] pwdata;
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic [level_width-1:0]    xdac;
    logic [level_width-1:0]    ydac;

    // Parsed golden commands, one entry per line
    byte         cmd_q [$];
    logic [31:0] arg0_q [$];
    logic [31:0] arg1_q [$];
    logic [31:0] arg2_q [$];
    string       name_q [$];

    string cur_name     = "";
    int    test_checks  = 0;
    int    test_errors  = 0;
    int    checks       = 0;
    int    errors       = 0;
    int    passed       = 0;
    int    failed       = 0;
    int    limit_cycles = 0;
    bit    bad_file     = 1'b0;

    vector_wave_gen vector_wave_gen_inst (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .xdac    (xdac),
        .ydac    (ydac)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Golden file
    ////////////////////////////////////////////////////////////

    task automatic store_cmd(input byte c, input logic [31:0] v0, input logic [31:0] v1,
                             input logic [31:0] v2, input string nm);
        cmd_q.push_back(c);
        arg0_q.push_back(v0);
        arg1_q.push_back(v1);
        arg2_q.push_back(v2);
        name_q.push_back(nm);
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        int          line_no;
        int          wait_total;
        int          apb_count;
        string       line;
        string       tok;
        string       nm;
        logic [31:0] v0;
        logic [31:0] v1;
        logic [31:0] v2;
        line_no    = 0;
        wait_total = 0;
        apb_count  = 0;
        fd = $fopen("wave_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open wave_golden.txt");
            bad_file = 1'b1;
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                tok = "";
                n = $sscanf(line, "%s", tok);
                if (n < 1 || tok.getc(0) == "#")
                    continue;                   // Blank or comment line
                v0 = '0;
                v1 = '0;
                v2 = '0;
                nm = "";
                case (tok)
                    "T": n = $sscanf(line, "%s %s", tok, nm) - 1;
                    "W": n = $sscanf(line, "%s %h %h", tok, v0, v1) - 2;
                    "R": n = $sscanf(line, "%s %h %h %h", tok, v0, v1, v2) - 3;
                    "C": n = $sscanf(line, "%s %d %h %h", tok, v0, v1, v2) - 3;
                    default: n = 0;
                endcase
                if (n != 1) begin
                    $display("Line %0d of wave_golden.txt is not a valid command", line_no);
                    bad_file = 1'b1;
                end else begin
                    store_cmd(tok.getc(0), v0, v1, v2, nm);
                    if (tok == "C")
                        wait_total += int'(v0);
                    else if (tok != "T")
                        apb_count++;
                end
            end
            $fclose(fd);
        end
        // Reset, every wait, four cycles per bus transfer and some slack
        limit_cycles = wait_total + 4 * apb_count + 20;
    endtask

    ////////////////////////////////////////////////////////////
    // Bus and check tasks
    ////////////////////////////////////////////////////////////

    task automatic compare(input string what, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
        checks++;
        test_checks++;
        if (act_v !== exp_v) begin
            errors++;
            test_errors++;
            $display("Error %s %s: expected 0x%0h, actual 0x%0h", cur_name, what, exp_v, act_v);
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic write_reg(input logic [apb_addr_width-1:0] addr,
                             input logic [apb_data_width-1:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        @(posedge clk);                         // Register written here
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_reg(input logic [apb_addr_width-1:0] addr,
                            input logic [apb_data_width-1:0] exp_data, input logic exp_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        #1;                                     // Mid access phase
        compare("prdata", exp_data, prdata);
        compare("pslverr", 32'(exp_err), 32'(pslverr));
        compare("pready", 32'd1, 32'(pready));
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_cycles(input int n, input logic [7:0] exp_x, input logic [7:0] exp_y);
        repeat (n) @(posedge clk);
        #1;
        compare("xdac", 32'(exp_x), 32'(xdac));
        compare("ydac", 32'(exp_y), 32'(ydac));
    endtask

    task automatic close_test();
        if (cur_name != "") begin
            if (test_errors == 0) begin
                passed++;
                $display("Test %s: ok, %0d checks", cur_name, test_checks);
            end else begin
                failed++;
                $display("Test %s: failed, %0d of %0d checks wrong",
                         cur_name, test_errors, test_checks);
            end
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        reset   = 1'b1;
        load_golden();
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        if (!bad_file) begin
            for (int i = 0; i < cmd_q.size(); i++) begin
                case (cmd_q[i])
                    "T": begin
                        close_test();
                        cur_name = name_q[i];
                    end
                    "W": write_reg(arg0_q[i][7:0], arg1_q[i]);
                    "R": read_reg(arg0_q[i][7:0], arg1_q[i], arg2_q[i][0]);
                    "C": run_cycles(int'(arg0_q[i]), arg1_q[i][7:0], arg2_q[i][7:0]);
                    default: ;
                endcase
            end
        end
        close_test();
        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 passed, failed, checks, errors);
        if (errors == 0 && !bad_file)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        wait (limit_cycles != 0);
        #(limit_cycles * clk_period);
        $display("Timeout after %0d cycles, the test sequence did not complete", limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* vector_wave_gen.sv */
// Vector waveform generator top level
`default_nettype none

module vector_wave_gen
    import wave_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // APB slave
    input  logic [apb_addr_width-1:0] paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_data_width-1:0] pwdata,
    output logic [apb_data_width-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,

    // DAC levels
    output logic [level_width-1:0]    xdac,
    output logic [level_width-1:0]    ydac
);

    logic                   x_enable;
    logic                   y_enable;
    wave_op_t               x_op;
    wave_op_t               y_op;
    logic [level_width-1:0] x_a;
    logic [level_width-1:0] x_b;
    logic [level_width-1:0] y_a;
    logic [level_width-1:0] y_b;
    logic [ptr_width-1:0]   x_ptr;
    logic [ptr_width-1:0]   y_ptr;

    wave_regs regs_inst (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .x_ptr    (x_ptr),
        .y_ptr    (y_ptr),
        .x_enable (x_enable),
        .x_op     (x_op),
        .x_a      (x_a),
        .x_b      (x_b),
        .y_enable (y_enable),
        .y_op     (y_op),
        .y_a      (y_a),
        .y_b      (y_b)
    );

    // X channel
    wave_channel x_channel (
        .clk    (clk),
        .reset  (reset),
        .enable (x_enable),
        .op     (x_op),
        .a      (x_a),
        .b      (x_b),
        .ptr    (x_ptr),
        .level  (xdac)
    );

    // Y channel
    wave_channel y_channel (
        .clk    (clk),
        .reset  (reset),
        .enable (y_enable),
        .op     (y_op),
        .a      (y_a),
        .b      (y_b),
        .ptr    (y_ptr),
        .level  (ydac)
    );

endmodule

`default_nettype wire

/* wave_channel.sv */
// Channel instruction sequencer
`default_nettype none

module wave_channel
    import wave_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  wave_op_t               op,
    input  logic [level_width-1:0] a,
    input  logic [level_width-1:0] b,
    output logic [ptr_width-1:0]   ptr,
    output logic [level_width-1:0] level  // Drives the DAC directly
);

    seg_t                   seg;
    seg_t                   seg_next;
    logic [level_width-1:0] cnt;          // Steps done in the segment
    logic [level_width-1:0] cnt_next;
    logic [level_width-1:0] level_next;
    slope_t                 step_slope;
    logic                   load_step;    // Level takes a instead of a slope
    logic                   instr_done;   // Last step of the instruction
    logic [2:0]             act;          // Active rectangle segment, 4 means none
    logic [2:0]             act_after;    // Segment that follows it
    logic [level_width-1:0] seg_len;

    // First rectangle segment at or after start with a nonzero count.
    // Segment lengths run a, b, a, b for both rectangle kinds
    function automatic logic [2:0] next_active(
        input logic [2:0]             start,
        input logic [level_width-1:0] len_a,
        input logic [level_width-1:0] len_b
    );
        logic [2:0] idx;
        idx = 3'd4;
        for (int i = 3; i >= 0; i--) begin
            if (i >= int'(start) && ((i % 2 == 1) ? len_b : len_a) != '0)
                idx = 3'(i);
        end
        return idx;
    endfunction

    assign act       = next_active({1'b0, seg}, a, b);
    assign act_after = next_active(act + 3'd1, a, b);
    assign seg_len   = act[0] ? b : a;

    ////////////////////////////////////////////////////////////
    // Step decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        step_slope = slope_hold;
        load_step  = 1'b0;
        instr_done = 1'b0;
        seg_next   = seg;
        cnt_next   = cnt + 8'd1;

        case (op)
            op_jump: begin
                load_step  = 1'b1;
                instr_done = 1'b1;
            end
            op_incr: begin
                if (a != '0)
                    step_slope = slope_up;
                instr_done = (cnt_next >= a);  // a of 0 ends at once
            end
            op_dcre: begin
                if (a != '0)
                    step_slope = slope_down;
                instr_done = (cnt_next >= a);
            end
            op_line: begin
                if (seg == seg_0) begin       // Load a on the first step
                    load_step = 1'b1;
                    if (a == b)
                        instr_done = 1'b1;
                    else
                        seg_next = seg_1;
                end else if (level < b) begin
                    step_slope = slope_up;
                    instr_done = (level + 8'd1 == b);
                end else if (level > b) begin
                    step_slope = slope_down;
                    instr_done = (level - 8'd1 == b);
                end else begin
                    instr_done = 1'b1;        // Already there
                end
            end
            op_x_rect, op_y_rect: begin
                if (act[2]) begin
                    instr_done = 1'b1;        // All counts zero
                end else begin
                    case (act[1:0])
                        2'd0: step_slope = (op == op_x_rect) ? slope_up   : slope_hold;
                        2'd1: step_slope = (op == op_x_rect) ? slope_hold : slope_up;
                        2'd2: step_slope = (op == op_x_rect) ? slope_down : slope_hold;
                        default: step_slope = (op == op_x_rect) ? slope_hold : slope_down;
                    endcase
                    if (cnt_next >= seg_len) begin
                        if (act_after[2]) begin
                            instr_done = 1'b1;
                        end else begin
                            seg_next = seg_t'(act_after[1:0]); // Skip empty segments
                            cnt_next = '0;
                        end
                    end else begin
                        seg_next = seg_t'(act[1:0]);
                    end
                end
            end
            default: instr_done = 1'b1;       // NOP and opcode 7
        endcase

        if (instr_done) begin
            seg_next = seg_0;
            cnt_next = '0;
        end
    end

    // Level arithmetic wraps modulo 256
    always_comb begin
        if (load_step)
            level_next = a;
        else begin
            case (step_slope)
                slope_up:   level_next = level + 8'd1;
                slope_down: level_next = level - 8'd1;
                default:    level_next = level;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // State
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr   <= '0;
            seg   <= seg_0;
            cnt   <= '0;
            level <= '0;
        end else if (!enable) begin
            // Back to the start of the program, level holds
            ptr <= '0;
            seg <= seg_0;
            cnt <= '0;
        end else begin
            level <= level_next;
            seg   <= seg_next;
            cnt   <= cnt_next;
            if (instr_done)
                ptr <= ptr + 3'd1;            // Wraps 7 to 0
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // Only loads may jump, every other step moves by one at most
    assert property (@(posedge clk) disable iff (reset)
        !load_step |=> (level == $past(level) ||
                        level == $past(level) + 8'd1 ||
                        level == $past(level) - 8'd1));

    assert property (@(posedge clk) disable iff (reset)
        !enable |=> (ptr == '0));

endmodule

`default_nettype wire

/* wave_golden.txt */
# T name | W addr data | R addr data pslverr | C cycles xdac ydac
# All values hex except the cycle count of C, which is decimal
T register_access
R 00 00000000 0
R 04 00000000 0
W 40 ffffff04
R 40 00ffff04 0
W 7c 12345607
R 7c 00345607 0
R 20 00000000 1
T single_step_x
W 40 00000a04
W 44 00000502
W 48 00000303
W 4c 00000000
W 50 00000000
W 54 00000000
W 58 00000000
W 5c 00000000
W 00 00000001
C 1 0a 00
C 2 0c 00
C 3 0f 00
C 2 0d 00
C 6 0c 00
C 1 0a 00
C 1 0b 00
T line_ramps
W 00 00000000
W 40 00191401
W 44 00252801
W 48 00000000
W 00 00000001
C 1 14 00
C 2 16 00
C 3 19 00
C 1 28 00
C 2 26 00
C 1 25 00
C 7 14 00
T rectangles
W 00 00000000
W 40 00003204
W 44 00030205
W 60 00006404
W 64 00020006
W 68 00000000
W 6c 00000000
W 70 00000000
W 74 00000000
W 78 00000000
W 7c 00000000
W 00 00000003
C 1 32 64
C 2 34 66
C 1 34 65
C 3 33 64
C 1 32 64
C 4 32 64
T disable_restart
W 00 00000000
C 3 32 66
R 04 00000000 0
W 40 00007704
W 00 00000003
C 1 77 64
C 1 78 65
T loop_wrap
W 00 00000000
W 40 00000504
W 44 00001504
W 48 00002504
W 4c 00003504
W 50 00004504
W 54 00005504
W 58 00006504
W 5c 00007504
W 00 00000001
C 1 05 65
C 3 35 65
R 04 00000005 0
C 2 75 65
C 1 05 65
C 1 15 65
R 04 00000003 0

/* wave_pkg.sv */
// Vector waveform generator definitions
`default_nettype none

package wave_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int level_width    = 8;   // DAC level and instruction parameters
    localparam int prog_depth     = 8;   // Instructions per channel
    localparam int ptr_width      = 3;   // Instruction pointer
    localparam int apb_addr_width = 8;
    localparam int apb_data_width = 32;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    localparam logic [apb_addr_width-1:0] ctrl_addr   = 8'h00; // Bit 0 X enable, bit 1 Y enable
    localparam logic [apb_addr_width-1:0] status_addr = 8'h04; // Read-only pointers
    localparam logic [apb_addr_width-1:0] prog_x_base = 8'h40; // Eight words
    localparam logic [apb_addr_width-1:0] prog_y_base = 8'h60; // Eight words

    // Program word layout
    localparam int op_lsb = 0;
    localparam int a_lsb  = 8;
    localparam int b_lsb  = 16;

    ////////////////////////////////////////////////////////////
    // Opcodes and sequencer states
    ////////////////////////////////////////////////////////////

    // Opcode 7 is left unassigned and executes as a NOP
    typedef enum logic [2:0] {
        op_nop    = 3'd0,
        op_line   = 3'd1,
        op_incr   = 3'd2,
        op_dcre   = 3'd3,
        op_jump   = 3'd4,
        op_x_rect = 3'd5,
        op_y_rect = 3'd6
    } wave_op_t;

    // Segment within an instruction
    typedef enum logic [1:0] {
        seg_0,
        seg_1,
        seg_2,
        seg_3
    } seg_t;

    // Level action for one step
    typedef enum logic [1:0] {
        slope_up,
        slope_down,
        slope_hold
    } slope_t;

endpackage

`default_nettype wire

/* wave_regs.sv */
// APB register block
`default_nettype none

module wave_regs
    import wave_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // APB slave
    input  logic [apb_addr_width-1:0] paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_data_width-1:0] pwdata,
    output logic [apb_data_width-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,

    // Channel pointers back from the sequencers
    input  logic [ptr_width-1:0]      x_ptr,
    input  logic [ptr_width-1:0]      y_ptr,

    // Current X instruction
    output logic                      x_enable,
    output wave_op_t                  x_op,
    output logic [level_width-1:0]    x_a,
    output logic [level_width-1:0]    x_b,

    // Current Y instruction
    output logic                      y_enable,
    output wave_op_t                  y_op,
    output logic [level_width-1:0]    y_a,
    output logic [level_width-1:0]    y_b
);

    logic [1:0]           ctrl;           // {y_enable, x_enable}
    logic                 ctrl_hit;
    logic                 status_hit;
    logic                 x_hit;
    logic                 y_hit;
    logic                 access;
    logic                 wr_en;
    logic [ptr_width-1:0] word_idx;

    // Program storage, index 0 is X and 1 is Y
    wave_op_t             op_mem [2][prog_depth];
    logic [level_width-1:0] a_mem [2][prog_depth];
    logic [level_width-1:0] b_mem [2][prog_depth];

    function automatic logic [apb_data_width-1:0] pack_word(
        input wave_op_t               op,
        input logic [level_width-1:0] pa,
        input logic [level_width-1:0] pb
    );
        logic [apb_data_width-1:0] w;
        w = '0;
        w[op_lsb +: 3]         = op;
        w[a_lsb +: level_width] = pa;
        w[b_lsb +: level_width] = pb;
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign ctrl_hit   = (paddr == ctrl_addr);
    assign status_hit = (paddr == status_addr);
    // Program windows are 32 bytes, word aligned only
    assign x_hit      = (paddr[7:5] == prog_x_base[7:5]) && (paddr[1:0] == 2'b00);
    assign y_hit      = (paddr[7:5] == prog_y_base[7:5]) && (paddr[1:0] == 2'b00);
    assign word_idx   = paddr[4:2];

    assign access = psel && penable;
    assign wr_en  = access && pwrite;
    assign pready = 1'b1;                 // No wait states

    // Status is read-only, so a write there is an error too
    always_comb begin
        if (!access)
            pslverr = 1'b0;
        else if (pwrite)
            pslverr = !(ctrl_hit || x_hit || y_hit);
        else
            pslverr = !(ctrl_hit || status_hit || x_hit || y_hit);
    end

    always_comb begin
        prdata = '0;
        if (ctrl_hit)
            prdata[1:0] = ctrl;
        else if (status_hit) begin
            prdata[2:0] = x_ptr;
            prdata[6:4] = y_ptr;
        end else if (x_hit)
            prdata = pack_word(op_mem[0][word_idx], a_mem[0][word_idx], b_mem[0][word_idx]);
        else if (y_hit)
            prdata = pack_word(op_mem[1][word_idx], a_mem[1][word_idx], b_mem[1][word_idx]);
    end

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset)
            ctrl <= 2'b00;
        else if (wr_en && ctrl_hit)
            ctrl <= pwdata[1:0];
    end

    always_ff @(posedge clk) begin
        if (wr_en && (x_hit || y_hit)) begin
            op_mem[y_hit][word_idx] <= wave_op_t'(pwdata[op_lsb +: 3]);
            a_mem[y_hit][word_idx]  <= pwdata[a_lsb +: level_width];
            b_mem[y_hit][word_idx]  <= pwdata[b_lsb +: level_width];
        end
    end

    // Instruction fetch follows each channel pointer
    assign x_enable = ctrl[0];
    assign x_op     = op_mem[0][x_ptr];
    assign x_a      = a_mem[0][x_ptr];
    assign x_b      = b_mem[0][x_ptr];

    assign y_enable = ctrl[1];
    assign y_op     = op_mem[1][y_ptr];
    assign y_a      = a_mem[1][y_ptr];
    assign y_b      = b_mem[1][y_ptr];

    ////////////////////////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////////////////////////

    // Access phase only directly after a setup phase
    assert property (@(posedge clk) disable iff (reset)
        penable |-> $past(psel && !penable));

    // Setup phase moves into the access phase with psel held
    assert property (@(posedge clk) disable iff (reset)
        (psel && !penable) |=> (psel && penable));

endmodule

`default_nettype wire
